//--- include/serial_params.svh
`ifndef SERIAL_PARAMS_SVH
`define SERIAL_PARAMS_SVH

// first fetch address after reset
`define SERIAL_RESET_PC 32'h0000_0000

// number of implemented integer registers, x0 included
`define SERIAL_NUM_REGS 8

// major opcodes of the supported instructions
`define SERIAL_OP_REG    7'b0110011
`define SERIAL_OP_IMM    7'b0010011
`define SERIAL_OP_LOAD   7'b0000011
`define SERIAL_OP_STORE  7'b0100011
`define SERIAL_OP_BRANCH 7'b1100011

// funct3 of bne, beq uses 3'b000
`define SERIAL_F3_BNE 3'b001

`endif

//--- src/serial_pkg.sv
`default_nettype none

// shared types for the bit-serial core
package serial_pkg;

   // one architectural word, used for data, addresses and instructions
   typedef logic [31:0] word_t;

   // only x0 to x7 exist, so the upper two index bits of rd/rs1/rs2 are dropped
   typedef logic [2:0] reg_idx_t;

   // bit position within one 32 cycle serial pass
   typedef logic [4:0] bit_cnt_t;

   // top two bits of the word counter, each value covers eight bit positions
   typedef logic [1:0] byte_sel_t;

   // decoded instruction control
   typedef struct packed {
      reg_idx_t rd;
      reg_idx_t rs1;
      reg_idx_t rs2;
      // the instruction writes rd (add, addi, lw)
      logic     rd_op;
      // second adder operand comes from the immediate instead of rs2
      logic     imm_op;
      // lw or sw, needs the data port after the address pass
      logic     mem_op;
      logic     store_op;
      logic     branch_op;
      // branch is taken on inequality instead of equality
      logic     bne_op;
      // instruction needs an init pass before its final pass
      logic     two_stage_op;
   } dec_ctrl_t;

   // request on the single memory port, wdata is ignored for reads
   typedef struct packed {
      word_t addr;
      logic  we;
      word_t wdata;
   } mem_req_t;

endpackage

`default_nettype wire

//--- src/serial_state.sv
`timescale 1ns/1ns
`default_nettype none

module serial_state (
   input  wire                   i_clk,
   input  wire                   i_rst,
   input  wire                   i_fetch_ack,
   input  wire                   i_data_ack,
   input  wire serial_pkg::dec_ctrl_t i_ctrl,
   input  wire                   i_cmp_eq,
   output serial_pkg::bit_cnt_t  o_cnt,
   output logic                  o_cnt_en,
   output logic                  o_init,
   output logic                  o_cnt_done,
   output logic                  o_rf_wen,
   output logic                  o_bufreg_en,
   output logic                  o_pc_en,
   output logic                  o_jump,
   output logic                  o_fetch_valid,
   output logic                  o_data_valid
);

   // upper three bits of the bit position, stepped once every four cycles
   logic [2:0] word_cnt;
   // looping one-hot marker for the lower two bits, all zero while idle
   logic [3:0] cnt_r;
   // set once the init pass of a two-stage instruction is finished
   logic       init_done;
   logic       fetch_req;
   logic       data_req;
   // low only in the first cycle after reset so the first fetch can start
   logic       booted;
   logic       cnt_start;
   logic       take_branch;

   // the counter is running whenever the one-hot marker sits somewhere
   assign o_cnt_en = |cnt_r;

   // rebuild the binary position from the one-hot lower part
   assign o_cnt = {word_cnt, cnt_r[3] | cnt_r[2], cnt_r[3] | cnt_r[1]};

   assign o_cnt_done = (word_cnt == 3'b111) & cnt_r[3];

   // memory and branch instructions run their first pass as init
   assign o_init = i_ctrl.two_stage_op & ~init_done;

   // rd is only written in the final pass, for lw that is the load pass
   assign o_rf_wen = o_cnt_en & i_ctrl.rd_op & ~o_init;

   // the address for lw/sw is collected during the init pass
   assign o_bufreg_en = o_cnt_en & o_init & i_ctrl.mem_op;

   // one-stage ops update the PC in their only pass
   // lw/sw step the PC in the address pass since their final pass never touches it
   // branches leave the PC alone in the compare pass and update it in the second
   assign o_pc_en = o_cnt_en & (~i_ctrl.two_stage_op | (o_init ^ i_ctrl.branch_op));

   // beq is taken on equality, bne on inequality
   // only meaningful in the last cycle of the compare pass
   assign take_branch = i_ctrl.branch_op & (i_cmp_eq ^ i_ctrl.bne_op);

   // a pass starts after a fetch, after a load handshake, or right after
   // the compare pass of a branch
   assign cnt_start = i_fetch_ack |
                      (i_data_ack & ~i_ctrl.store_op) |
                      (o_cnt_done & o_init & i_ctrl.branch_op);

   assign o_fetch_valid = fetch_req;
   assign o_data_valid  = data_req;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         word_cnt  <= 3'd0;
         cnt_r     <= 4'b0000;
         init_done <= 1'b0;
         o_jump    <= 1'b0;
         fetch_req <= 1'b0;
         data_req  <= 1'b0;
         booted    <= 1'b0;
      end else begin
         word_cnt <= word_cnt + {2'd0, cnt_r[3]};
         // the marker loops until done blocks its way back into bit 0
         cnt_r    <= {cnt_r[2:0], (cnt_r[3] & ~o_cnt_done) | cnt_start};
         booted   <= 1'b1;

         // a new instruction always begins with init_done cleared
         // a store never runs a second pass, so this is where it is reset
         if (i_fetch_ack) begin
            init_done <= 1'b0;
         end else if (o_cnt_done) begin
            init_done <= o_init;
         end

         // the decision is held for the whole second pass of a branch
         if (o_cnt_done) begin
            o_jump <= o_init & take_branch;
         end

         // fetch follows the final pass, or the data handshake of a store
         if (i_fetch_ack) begin
            fetch_req <= 1'b0;
         end else if (~booted | (o_cnt_done & ~o_init) |
                      (i_data_ack & i_ctrl.store_op)) begin
            fetch_req <= 1'b1;
         end

         // the data request waits for the address pass to finish
         if (i_data_ack) begin
            data_req <= 1'b0;
         end else if (o_cnt_done & o_init & i_ctrl.mem_op) begin
            data_req <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- src/serial_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "serial_params.svh"

module serial_decode (
   input  wire                   i_clk,
   input  wire                   i_rst,
   input  wire                   i_fetch_ack,
   input  wire serial_pkg::word_t    i_instr,
   input  wire serial_pkg::bit_cnt_t i_cnt,
   output serial_pkg::dec_ctrl_t o_ctrl,
   output logic                  o_imm_bit
);

   serial_pkg::word_t     instr_q;
   serial_pkg::byte_sel_t byte_sel;
   logic [6:0]            opcode;
   logic [2:0]            funct3;
   logic                  is_reg;
   logic                  is_imm;
   logic                  is_load;
   logic                  is_store;
   logic                  is_branch;
   logic                  sign_zone;
   // immediate bits 0 to 11 for each format, upper four bits are never selected
   logic [15:0]           imm_i;
   logic [15:0]           imm_s;
   logic [15:0]           imm_b;
   logic [15:0]           imm_low;

   // the fetched word is only valid in the handshake cycle
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         instr_q <= '0;
      end else if (i_fetch_ack) begin
         instr_q <= i_instr;
      end
   end

   assign opcode = instr_q[6:0];
   assign funct3 = instr_q[14:12];

   assign is_reg    = (opcode == `SERIAL_OP_REG);
   assign is_imm    = (opcode == `SERIAL_OP_IMM);
   assign is_load   = (opcode == `SERIAL_OP_LOAD);
   assign is_store  = (opcode == `SERIAL_OP_STORE);
   assign is_branch = (opcode == `SERIAL_OP_BRANCH);

   always_comb begin
      // register fields keep only the low three bits
      o_ctrl.rd           = instr_q[9:7];
      o_ctrl.rs1          = instr_q[17:15];
      o_ctrl.rs2          = instr_q[22:20];
      o_ctrl.rd_op        = is_reg | is_imm | is_load;
      o_ctrl.imm_op       = is_imm | is_load | is_store;
      o_ctrl.mem_op       = is_load | is_store;
      o_ctrl.store_op     = is_store;
      o_ctrl.branch_op    = is_branch;
      o_ctrl.bne_op       = is_branch & (funct3 == `SERIAL_F3_BNE);
      o_ctrl.two_stage_op = is_load | is_store | is_branch;
   end

   // I format keeps the immediate in one piece at the top
   assign imm_i = {4'd0, instr_q[31:20]};
   // S format splits it around rs2
   assign imm_s = {4'd0, instr_q[31:25], instr_q[11:7]};
   // B format has bit 0 fixed at zero and bit 11 moved down to instr bit 7
   assign imm_b = {4'd0, instr_q[7], instr_q[30:25], instr_q[11:8], 1'b0};

   assign imm_low = is_branch ? imm_b : (is_store ? imm_s : imm_i);

   // positions 12 to 31 all repeat the sign bit in every format
   assign byte_sel  = i_cnt[4:3];
   assign sign_zone = byte_sel[1] | (byte_sel[0] & i_cnt[2]);

   assign o_imm_bit = sign_zone ? instr_q[31] : imm_low[i_cnt[3:0]];

endmodule

`default_nettype wire

//--- src/serial_datapath.sv
`timescale 1ns/1ns
`default_nettype none

`include "serial_params.svh"

module serial_datapath (
   input  wire                   i_clk,
   input  wire                   i_rst,
   input  wire serial_pkg::dec_ctrl_t i_ctrl,
   input  wire                   i_imm_bit,
   input  wire serial_pkg::bit_cnt_t  i_cnt,
   input  wire                   i_cnt_en,
   input  wire                   i_init,
   input  wire                   i_cnt_done,
   input  wire                   i_rf_wen,
   input  wire                   i_bufreg_en,
   input  wire                   i_pc_en,
   input  wire                   i_jump,
   input  wire                   i_data_ack,
   input  wire serial_pkg::word_t    i_rdata,
   output logic                  o_cmp_eq,
   output serial_pkg::word_t     o_pc,
   output serial_pkg::mem_req_t  o_data_req
);

   serial_pkg::word_t regs [`SERIAL_NUM_REGS];
   serial_pkg::word_t bufreg;
   serial_pkg::word_t ld_shift;
   serial_pkg::word_t pc;
   serial_pkg::word_t rs2_word;
   logic              rs1_bit;
   logic              rs2_bit;
   logic              op_b;
   logic              sum;
   logic              alu_carry;
   logic              rd_bit;
   logic              eq_r;
   logic              pc_b;
   logic              pc_sum;
   logic              pc_carry;

   // x0 is forced to zero on every read path
   assign rs1_bit  = (i_ctrl.rs1 == 3'd0) ? 1'b0 : regs[i_ctrl.rs1][i_cnt];
   assign rs2_bit  = (i_ctrl.rs2 == 3'd0) ? 1'b0 : regs[i_ctrl.rs2][i_cnt];
   // full rs2 word for store data, stable while the data request waits
   assign rs2_word = (i_ctrl.rs2 == 3'd0) ? '0 : regs[i_ctrl.rs2];

   // one shared adder serves add, addi and the lw/sw address
   assign op_b = i_ctrl.imm_op ? i_imm_bit : rs2_bit;
   assign sum  = rs1_bit ^ op_b ^ alu_carry;

   // a load writes rd from the captured word, everything else from the adder
   assign rd_bit = i_ctrl.mem_op ? ld_shift[0] : sum;

   // equality so far including the current bit, complete at the done cycle
   assign o_cmp_eq = eq_r & ~(rs1_bit ^ rs2_bit);

   // the PC adds four unless a taken branch supplies its offset
   assign pc_b   = i_jump ? i_imm_bit : (i_cnt == 5'd2);
   assign pc_sum = pc[0] ^ pc_b ^ pc_carry;

   assign o_pc = pc;

   assign o_data_req.addr  = bufreg;
   assign o_data_req.we    = i_ctrl.store_op;
   assign o_data_req.wdata = rs2_word;

   // register array, writes land bit by bit at the current position
   // the bit is read before its own write, so rd may equal rs1 or rs2
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < `SERIAL_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_rf_wen && (i_ctrl.rd != 3'd0)) begin
         regs[i_ctrl.rd][i_cnt] <= rd_bit;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         alu_carry <= 1'b0;
         pc_carry  <= 1'b0;
         eq_r      <= 1'b1;
         bufreg    <= '0;
         ld_shift  <= '0;
         pc        <= `SERIAL_RESET_PC;
      end else begin
         // carries start every pass from zero
         if (i_cnt_en & ~i_cnt_done) begin
            alu_carry <= (rs1_bit & op_b) | (alu_carry & (rs1_bit ^ op_b));
         end else begin
            alu_carry <= 1'b0;
         end

         if (i_pc_en & ~i_cnt_done) begin
            pc_carry <= (pc[0] & pc_b) | (pc_carry & (pc[0] ^ pc_b));
         end else begin
            pc_carry <= 1'b0;
         end

         // the compare only runs in the init pass of a branch
         if (~i_cnt_en | i_cnt_done) begin
            eq_r <= 1'b1;
         end else if (i_init) begin
            eq_r <= o_cmp_eq;
         end

         // address bits enter at the top, LSB first
         if (i_bufreg_en) begin
            bufreg <= {sum, bufreg[31:1]};
         end

         // load data is grabbed at the handshake and drained into rd LSB first
         if (i_data_ack & ~i_ctrl.store_op) begin
            ld_shift <= i_rdata;
         end else if (i_rf_wen & i_ctrl.mem_op) begin
            ld_shift <= {1'b0, ld_shift[31:1]};
         end

         // the PC rotates through its own adder and is whole again after done
         if (i_pc_en) begin
            pc <= {pc_sum, pc[31:1]};
         end
      end
   end

endmodule

`default_nettype wire

//--- src/mem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter (
   input  wire                   i_clk,
   input  wire                   i_rst,
   input  wire                   i_fetch_valid,
   input  wire serial_pkg::mem_req_t i_fetch_req,
   input  wire                   i_data_valid,
   input  wire serial_pkg::mem_req_t i_data_req,
   input  wire                   i_mem_ready,
   output logic                  o_fetch_ack,
   output logic                  o_data_ack,
   output logic                  o_mem_valid,
   output serial_pkg::mem_req_t  o_mem_req
);

   // a stalled request keeps the port until memory takes it
   logic locked;
   logic gnt_data_q;
   logic sel_data;

   // when free, data access has priority over fetch
   assign sel_data = locked ? gnt_data_q : i_data_valid;

   assign o_mem_valid = sel_data ? i_data_valid : i_fetch_valid;
   assign o_mem_req   = sel_data ? i_data_req : i_fetch_req;

   // ready only reaches the requester that owns the port
   assign o_data_ack  = sel_data & i_data_valid & i_mem_ready;
   assign o_fetch_ack = ~sel_data & i_fetch_valid & i_mem_ready;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         locked     <= 1'b0;
         gnt_data_q <= 1'b0;
      end else if (o_mem_valid & ~i_mem_ready) begin
         locked     <= 1'b1;
         gnt_data_q <= sel_data;
      end else if (i_mem_ready) begin
         locked     <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- src/serial_core_top.sv
`timescale 1ns/1ns
`default_nettype none

module serial_core_top (
   input  wire                   i_clk,
   input  wire                   i_rst,
   input  wire                   i_mem_ready,
   input  wire serial_pkg::word_t    i_mem_rdata,
   output logic                  o_mem_valid,
   output serial_pkg::mem_req_t  o_mem_req
);

   serial_pkg::dec_ctrl_t ctrl;
   serial_pkg::bit_cnt_t  cnt;
   serial_pkg::word_t     pc;
   serial_pkg::mem_req_t  fetch_req;
   serial_pkg::mem_req_t  data_req;
   logic                  cnt_en;
   logic                  init;
   logic                  cnt_done;
   logic                  rf_wen;
   logic                  bufreg_en;
   logic                  pc_en;
   logic                  jump;
   logic                  cmp_eq;
   logic                  imm_bit;
   logic                  fetch_valid;
   logic                  data_valid;
   logic                  fetch_ack;
   logic                  data_ack;

   // instruction fetch is always a read at the current PC
   assign fetch_req = '{addr: pc, we: 1'b0, wdata: '0};

   serial_state state0 (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_fetch_ack  (fetch_ack),
      .i_data_ack   (data_ack),
      .i_ctrl       (ctrl),
      .i_cmp_eq     (cmp_eq),
      .o_cnt        (cnt),
      .o_cnt_en     (cnt_en),
      .o_init       (init),
      .o_cnt_done   (cnt_done),
      .o_rf_wen     (rf_wen),
      .o_bufreg_en  (bufreg_en),
      .o_pc_en      (pc_en),
      .o_jump       (jump),
      .o_fetch_valid(fetch_valid),
      .o_data_valid (data_valid)
   );

   serial_decode decode0 (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_fetch_ack(fetch_ack),
      .i_instr    (i_mem_rdata),
      .i_cnt      (cnt),
      .o_ctrl     (ctrl),
      .o_imm_bit  (imm_bit)
   );

   serial_datapath datapath0 (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_ctrl     (ctrl),
      .i_imm_bit  (imm_bit),
      .i_cnt      (cnt),
      .i_cnt_en   (cnt_en),
      .i_init     (init),
      .i_cnt_done (cnt_done),
      .i_rf_wen   (rf_wen),
      .i_bufreg_en(bufreg_en),
      .i_pc_en    (pc_en),
      .i_jump     (jump),
      .i_data_ack (data_ack),
      .i_rdata    (i_mem_rdata),
      .o_cmp_eq   (cmp_eq),
      .o_pc       (pc),
      .o_data_req (data_req)
   );

   // read data is shared, only the owner of the handshake samples it
   mem_arbiter arbiter0 (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_fetch_valid(fetch_valid),
      .i_fetch_req  (fetch_req),
      .i_data_valid (data_valid),
      .i_data_req   (data_req),
      .i_mem_ready  (i_mem_ready),
      .o_fetch_ack  (fetch_ack),
      .o_data_ack   (data_ack),
      .o_mem_valid  (o_mem_valid),
      .o_mem_req    (o_mem_req)
   );

endmodule

`default_nettype wire

//--- bench/tb_serial_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "serial_params.svh"

module tb_serial_core;

   // memory model covers byte addresses 0x000 to 0x1fc
   localparam int MEM_WORDS = 128;
   // longest run of ready low before the model forces a handshake
   localparam int MAX_STALL = 3;
   localparam int PASS_LEN = 32;

   // every expected store value is built from these program constants
   localparam int DATA_BASE = 256;
   localparam int IMM_A = 100;
   localparam int IMM_B = -7;
   localparam int LOOP_COUNT = 2;
   localparam int LOAD_OFF = 64;
   localparam int STORE_NEG = -4;

   logic                 clk = 1'b0;
   logic                 rst = 1'b1;
   logic                 mem_ready = 1'b0;
   serial_pkg::word_t    mem_rdata = '0;
   logic                 mem_valid;
   serial_pkg::mem_req_t mem_req;

   serial_pkg::word_t    mem [MEM_WORDS];
   // expected port transfers in order including fetches
   serial_pkg::mem_req_t exp_q [$];
   string                name_q [$];
   integer               seed = 32'h5f14c935;
   int                   stall_cnt = 0;
   int                   cycles = 0;
   int                   checked = 0;
   int                   mismatches = 0;
   int                   port_errors = 0;
   int                   other_errors = 0;
   logic                 timed_out = 1'b0;

   always #10 clk = ~clk;

   serial_core_top dut0 (
      .i_clk      (clk),
      .i_rst      (rst),
      .i_mem_ready(mem_ready),
      .i_mem_rdata(mem_rdata),
      .o_mem_valid(mem_valid),
      .o_mem_req  (mem_req)
   );

   // RV32I encodings where register fields take the full five bits
   function automatic serial_pkg::word_t addi_instr(input int rd, input int rs1, input int imm);
      return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], `SERIAL_OP_IMM};
   endfunction

   function automatic serial_pkg::word_t add_instr(input int rd, input int rs1, input int rs2);
      return {7'd0, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], `SERIAL_OP_REG};
   endfunction

   function automatic serial_pkg::word_t lw_instr(input int rd, input int rs1, input int imm);
      return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], `SERIAL_OP_LOAD};
   endfunction

   function automatic serial_pkg::word_t sw_instr(input int rs2, input int rs1, input int imm);
      return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], `SERIAL_OP_STORE};
   endfunction

   // offset is in bytes relative to the branch itself and bit 0 is dropped
   function automatic serial_pkg::word_t branch_instr(input logic [2:0] f3, input int rs1,
                                                      input int rs2, input int off);
      return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11],
              `SERIAL_OP_BRANCH};
   endfunction

   // background contents are a multiplicative hash of the byte address
   function automatic serial_pkg::word_t fill_word(input int addr);
      return 32'h6a09_e667 ^ (addr * 32'h9e37_79b1);
   endfunction

   task automatic place_instr(input int addr, input serial_pkg::word_t w);
      mem[addr / 4] = w;
   endtask

   task automatic expect_read(input string name, input int addr);
      serial_pkg::mem_req_t r;
      r.addr  = addr;
      r.we    = 1'b0;
      r.wdata = '0;
      exp_q.push_back(r);
      name_q.push_back(name);
   endtask

   task automatic expect_write(input string name, input int addr, input serial_pkg::word_t data);
      serial_pkg::mem_req_t r;
      r.addr  = addr;
      r.we    = 1'b1;
      r.wdata = data;
      exp_q.push_back(r);
      name_q.push_back(name);
   endtask

   // straight-line fetches from first to last inclusive
   task automatic expect_fetches(input int first, input int last);
      for (int a = first; a <= last; a += 4) begin
         expect_read("fetch", a);
      end
   endtask

   // compares one accepted transfer with the next entry of the expected list
   task automatic check_transfer(input serial_pkg::mem_req_t req);
      serial_pkg::mem_req_t exp;
      string                name;
      assert (req.addr[31:9] == '0) else begin
         other_errors = other_errors + 1;
         $display("access to address %h lies outside the memory model", req.addr);
      end
      // once the list is drained the core only spins on its halt branch
      if (exp_q.size() == 0) begin
         return;
      end
      exp  = exp_q.pop_front();
      name = name_q.pop_front();
      checked = checked + 1;
      assert (req.addr == exp.addr) else begin
         mismatches = mismatches + 1;
         $display("MISMATCH %s addr expected %h actual %h", name, exp.addr, req.addr);
      end
      assert (req.we == exp.we) else begin
         mismatches = mismatches + 1;
         $display("MISMATCH %s we expected %b actual %b", name, exp.we, req.we);
      end
      if (exp.we) begin
         assert (req.wdata == exp.wdata) else begin
            mismatches = mismatches + 1;
            $display("MISMATCH %s wdata expected %h actual %h", name, exp.wdata, req.wdata);
         end
      end
   endtask

   // the memory model drives everything on the falling edge so the values
   // seen here are the ones the DUT samples at the next rising edge
   always @(negedge clk) begin
      logic [31:0] draw;
      logic        ready_now;
      draw      = $random(seed);
      // roughly one cycle in four stalls, and a stall never runs past the cap
      ready_now = (draw[1:0] != 2'b00) || (stall_cnt >= MAX_STALL);
      mem_ready = ready_now;
      mem_rdata = mem[mem_req.addr[8:2]];
      if (mem_valid && ready_now) begin
         stall_cnt = 0;
         check_transfer(mem_req);
         if (mem_req.we) begin
            mem[mem_req.addr[8:2]] = mem_req.wdata;
         end
      end else if (mem_valid) begin
         stall_cnt = stall_cnt + 1;
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
   end

   // the port stays idle while reset is applied
   reset_idle: assert property (@(posedge clk) $past(rst) |-> !mem_valid)
      else begin
         port_errors = port_errors + 1;
         $display("memory valid was high while reset was applied");
      end

   // a stalled request keeps valid and every field until memory takes it
   stall_hold: assert property (@(posedge clk) disable iff (rst)
                                (mem_valid && !mem_ready) |=> (mem_valid && $stable(mem_req)))
      else begin
         port_errors = port_errors + 1;
         $display("request was dropped or changed while memory stalled it");
      end

   initial begin
      int limit;
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = fill_word(i * 4);
      end

      // set up x1 to x7 with an add of a negative operand and a wrapping add
      place_instr(32'h00, addi_instr(1, 0, IMM_A));
      place_instr(32'h04, addi_instr(2, 0, IMM_B));
      place_instr(32'h08, add_instr(3, 1, 2));
      place_instr(32'h0c, addi_instr(4, 0, DATA_BASE));
      place_instr(32'h10, sw_instr(3, 4, 0));
      place_instr(32'h14, sw_instr(2, 4, 4));
      place_instr(32'h18, addi_instr(5, 0, -1));
      place_instr(32'h1c, addi_instr(6, 0, LOOP_COUNT));
      place_instr(32'h20, add_instr(7, 5, 6));
      place_instr(32'h24, sw_instr(7, 4, 8));
      // load a background word and store it below the data base
      place_instr(32'h28, lw_instr(1, 4, LOAD_OFF));
      place_instr(32'h2c, sw_instr(1, 4, STORE_NEG));
      // a write to x0 must not stick
      place_instr(32'h30, addi_instr(0, 1, 5));
      place_instr(32'h34, sw_instr(0, 4, 12));
      // the skipped stores would show up as a transfer out of order
      place_instr(32'h38, branch_instr(3'b000, 3, 3, 8));
      place_instr(32'h3c, sw_instr(5, 4, 16));
      place_instr(32'h40, branch_instr(`SERIAL_F3_BNE, 3, 3, 8));
      place_instr(32'h44, branch_instr(3'b000, 3, 7, 8));
      place_instr(32'h48, branch_instr(`SERIAL_F3_BNE, 3, 7, 12));
      place_instr(32'h4c, sw_instr(5, 4, 16));
      place_instr(32'h50, sw_instr(5, 4, 16));
      // two loop turns with rd equal to rs1 are closed by a backward bne
      place_instr(32'h54, addi_instr(6, 6, -1));
      place_instr(32'h58, add_instr(2, 2, 3));
      place_instr(32'h5c, branch_instr(`SERIAL_F3_BNE, 6, 0, -8));
      place_instr(32'h60, sw_instr(2, 4, 16));
      place_instr(32'h64, branch_instr(3'b000, 0, 0, 0));

      expect_read("reset_fetch", `SERIAL_RESET_PC);
      expect_fetches(32'h04, 32'h10);
      expect_write("add", DATA_BASE, IMM_A + IMM_B);
      expect_read("fetch", 32'h14);
      expect_write("addi_neg", DATA_BASE + 4, IMM_B);
      expect_fetches(32'h18, 32'h24);
      expect_write("add_wrap", DATA_BASE + 8, -1 + LOOP_COUNT);
      expect_read("fetch", 32'h28);
      expect_read("load", DATA_BASE + LOAD_OFF);
      expect_read("fetch", 32'h2c);
      expect_write("lw_sw", DATA_BASE + STORE_NEG, fill_word(DATA_BASE + LOAD_OFF));
      expect_fetches(32'h30, 32'h34);
      expect_write("x0_zero", DATA_BASE + 12, 0);
      expect_read("fetch", 32'h38);
      expect_read("beq_taken", 32'h38 + 8);
      expect_read("bne_not_taken", 32'h40 + 4);
      expect_read("beq_not_taken", 32'h44 + 4);
      expect_read("bne_taken", 32'h48 + 12);
      expect_fetches(32'h58, 32'h5c);
      expect_read("bne_backward", 32'h5c - 8);
      expect_fetches(32'h58, 32'h5c);
      expect_read("loop_exit", 32'h5c + 4);
      expect_write("loop_acc", DATA_BASE + 16, IMM_B + LOOP_COUNT * (IMM_A + IMM_B));
      expect_read("fetch", 32'h64);
      expect_read("halt", 32'h64);

      // each transfer is followed by at most two passes and two stalled waits
      limit = 50 + exp_q.size() * 2 * (PASS_LEN + MAX_STALL + 2);

      repeat (4) @(negedge clk);
      rst = 1'b0;

      while (exp_q.size() != 0 && cycles < limit) @(posedge clk);
      timed_out = (exp_q.size() != 0);
      if (timed_out) begin
         $display("cycle limit %0d reached with %0d transfers still outstanding",
                  limit, exp_q.size());
      end
      repeat (2) @(posedge clk);

      $display("transfers %0d, mismatches %0d, port errors %0d, other errors %0d, timeouts %0d",
               checked, mismatches, port_errors, other_errors, timed_out);
      if (!timed_out && mismatches == 0 && port_errors == 0 && other_errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- all.f
+incdir+include
src/serial_pkg.sv
src/serial_state.sv
src/serial_decode.sv
src/serial_datapath.sv
src/mem_arbiter.sv
src/serial_core_top.sv
bench/tb_serial_core.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f all.f --top-module tb_serial_core
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/Vtb_serial_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "Verification passed" sim.log; then
   exit 0
else
   echo "simulation log does not report success"
   exit 1
fi
